//--- Makefile
# Verilator build and run of the CPU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module tb_cpu -f verilog.f
	@out="$$(./obj_dir/Vtb_cpu 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

//--- design/bus_master.sv
`timescale 1ns/1ns
// Read-only Wishbone classic master. Turns a one-cycle read request into a bus
// cycle and returns the captured byte with a one-cycle done pulse

module bus_master (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_rd_req,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] i_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0] o_rd_data,
  output logic                           o_rd_done,
  output logic                           o_wb_cyc,
  output logic                           o_wb_stb,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] o_wb_adr,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] i_wb_dat,
  input  logic                           i_wb_ack
);
  import cpu_pkg::*;

  typedef enum logic {
    BM_IDLE,
    BM_WAIT_ACK
  } bm_state_e;

  bm_state_e             state_q;
  logic [ADDR_WIDTH-1:0] adr_q;
  logic [DATA_WIDTH-1:0] dat_q;
  logic                  done_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= BM_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        BM_IDLE: begin
          if (i_rd_req) begin
            state_q <= BM_WAIT_ACK;
          end
        end
        BM_WAIT_ACK: begin
          if (i_wb_ack) begin
            state_q <= BM_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= BM_IDLE;
      endcase
    end
  end

  // Address is latched with the request and the byte with the ack
  always_ff @(posedge i_clk) begin
    if (state_q == BM_IDLE && i_rd_req) begin
      adr_q <= i_addr;
    end
    if (state_q == BM_WAIT_ACK && i_wb_ack) begin
      dat_q <= i_wb_dat;
    end
  end

  assign o_wb_cyc  = (state_q == BM_WAIT_ACK);
  assign o_wb_stb  = (state_q == BM_WAIT_ACK);
  assign o_wb_adr  = adr_q;
  assign o_rd_data = dat_q;
  assign o_rd_done = done_q;

  // No new read request may arrive while a cycle is still open
  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_wb_stb |-> (o_wb_cyc && !i_rd_req));

  a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_wb_stb && !i_wb_ack) |=> $stable(o_wb_adr));

endmodule

//--- design/cpu_pkg.sv
// Shared widths, opcode and microstep encodings and the control word of the CPU
// Every design module imports what it needs from here

package cpu_pkg;

  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 8;
  localparam int MAX_STEP   = 3;

  // Opcodes not listed here execute as a NOP
  typedef enum logic [7:0] {
    OP_NOP    = 8'h00,
    OP_MOV_AT = 8'h08,
    OP_MOV_AB = 8'h09,
    OP_MOV_AC = 8'h0a,
    OP_MOV_TA = 8'h0b,
    OP_MOV_TB = 8'h0c,
    OP_MOV_TC = 8'h0d,
    OP_MOV_BA = 8'h0e,
    OP_MOV_BT = 8'h0f,
    OP_MOV_BC = 8'h10,
    OP_MOV_CA = 8'h11,
    OP_MOV_CT = 8'h12,
    OP_MOV_CB = 8'h13,
    OP_OUT_A  = 8'h20,
    OP_OUT_T  = 8'h21,
    OP_OUT_B  = 8'h22,
    OP_OUT_C  = 8'h23,
    OP_LDI_A  = 8'h24,
    OP_LDI_B  = 8'h25,
    OP_LDI_C  = 8'h26,
    OP_JUMP   = 8'h27,
    OP_JIZ    = 8'h28,
    OP_JIC    = 8'h29,
    OP_ADDB   = 8'h34,
    OP_SUBB   = 8'h35,
    OP_ADDC   = 8'h36,
    OP_SUBC   = 8'h37,
    OP_HALT   = 8'hff
  } opcode_e;

  typedef enum logic [1:0] {
    STEP_FETCH_ADDR = 2'd0,
    STEP_FETCH_DATA = 2'd1,
    STEP_EX2        = 2'd2,
    STEP_EX3        = 2'd3
  } step_e;

  // A, T, B and C are kept in this order so a 2-bit register index maps onto them
  typedef enum logic [2:0] {
    SEL_NONE = 3'd0,
    SEL_A    = 3'd1,
    SEL_T    = 3'd2,
    SEL_B    = 3'd3,
    SEL_C    = 3'd4,
    SEL_PC   = 3'd5,
    SEL_MEM  = 3'd6
  } reg_sel_e;

  typedef struct packed {
    logic     mar_in;
    logic     mem_rd;
    logic     pc_out;
    logic     pc_inc;
    logic     jump;
    logic     ir_in;
    reg_sel_e src;
    reg_sel_e dst;
    logic     alu_out;
    logic     sub;
    logic     flags_in;
    logic     out_in;
    logic     advance;
    logic     halt;
  } ctrl_word_t;

  typedef struct packed {
    logic zero;
    logic carry;
  } flags_t;

endpackage

//--- design/cpu_top.sv
`timescale 1ns/1ns
// Top level of the accumulator CPU. Connects the sequencer, the datapath and
// the Wishbone read master to each other and to the external byte memory

module cpu_top (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  output logic                           o_wb_cyc,
  output logic                           o_wb_stb,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] o_wb_adr,
  input  logic [cpu_pkg::DATA_WIDTH-1:0] i_wb_dat,
  input  logic                           i_wb_ack,
  output logic [cpu_pkg::DATA_WIDTH-1:0] o_out_data,
  output logic                           o_out_valid,
  output logic                           o_halted
);
  import cpu_pkg::*;

  ctrl_word_t            ctrl;
  flags_t                flags;
  opcode_e               instr;
  logic [ADDR_WIDTH-1:0] mar;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  rd_req;
  logic                  rd_done;

  micro_sequencer seq0 (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_instr   (instr),
    .i_flags   (flags),
    .i_rd_done (rd_done),
    .o_ctrl    (ctrl),
    .o_rd_req  (rd_req),
    .o_halted  (o_halted)
  );

  datapath dp0 (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_ctrl      (ctrl),
    .i_rd_data   (rd_data),
    .i_rd_done   (rd_done),
    .o_instr     (instr),
    .o_flags     (flags),
    .o_mar       (mar),
    .o_out_data  (o_out_data),
    .o_out_valid (o_out_valid)
  );

  bus_master bm0 (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rd_req  (rd_req),
    .i_addr    (mar),
    .o_rd_data (rd_data),
    .o_rd_done (rd_done),
    .o_wb_cyc  (o_wb_cyc),
    .o_wb_stb  (o_wb_stb),
    .o_wb_adr  (o_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .i_wb_ack  (i_wb_ack)
  );

endmodule

//--- design/datapath.sv
`timescale 1ns/1ns
// Execute stage of the CPU. Holds PC, MAR, IR, registers A, T, B and C, the ALU,
// the flags and the output port, all loaded under the sequencer's control word

module datapath (
  input  logic                              i_clk,
  input  logic                              i_arst_n,
  input  cpu_pkg::ctrl_word_t               i_ctrl,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]    i_rd_data,
  input  logic                              i_rd_done,
  output cpu_pkg::opcode_e                  o_instr,
  output cpu_pkg::flags_t                   o_flags,
  output logic [cpu_pkg::ADDR_WIDTH-1:0]    o_mar,
  output logic [cpu_pkg::DATA_WIDTH-1:0]    o_out_data,
  output logic                              o_out_valid
);
  import cpu_pkg::*;

  logic [ADDR_WIDTH-1:0] pc_q;
  logic [ADDR_WIDTH-1:0] mar_q;
  logic [DATA_WIDTH-1:0] ir_q;
  logic [DATA_WIDTH-1:0] a_q;
  logic [DATA_WIDTH-1:0] t_q;
  logic [DATA_WIDTH-1:0] b_q;
  logic [DATA_WIDTH-1:0] c_q;
  logic [DATA_WIDTH-1:0] out_q;
  logic                  out_valid_q;
  flags_t                flags_q;
  flags_t                flags_d;
  logic [DATA_WIDTH-1:0] int_bus;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [DATA_WIDTH-1:0] alu_res;
  logic                  alu_carry;
  logic                  step_en;

  always_comb begin
    if (i_ctrl.pc_out) begin
      int_bus = pc_q;
    end else if (i_ctrl.alu_out) begin
      int_bus = alu_res;
    end else begin
      case (i_ctrl.src)
        SEL_A:   int_bus = a_q;
        SEL_T:   int_bus = t_q;
        SEL_B:   int_bus = b_q;
        SEL_C:   int_bus = c_q;
        SEL_MEM: int_bus = i_rd_data;
        default: int_bus = '0;
      endcase
    end
  end

  // Subtraction is A + ~T + 1, so carry set means no borrow
  assign alu_b = i_ctrl.sub ? ~t_q : t_q;
  assign {alu_carry, alu_res} = {1'b0, a_q} + {1'b0, alu_b} + {{DATA_WIDTH{1'b0}}, i_ctrl.sub};

  assign flags_d.zero  = (alu_res == '0);
  assign flags_d.carry = alu_carry;

  // Registers load in the single cycle of a plain step, or in the done cycle of a read
  assign step_en = !i_ctrl.mem_rd || i_rd_done;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q        <= '0;
      ir_q        <= '0;
      a_q         <= '0;
      t_q         <= '0;
      b_q         <= '0;
      c_q         <= '0;
      flags_q     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= step_en && i_ctrl.out_in;
      if (step_en) begin
        if (i_ctrl.jump) begin
          pc_q <= int_bus;
        end else if (i_ctrl.pc_inc) begin
          pc_q <= pc_q + 1'b1;
        end
        if (i_ctrl.ir_in) begin
          ir_q <= int_bus;
        end
        if (i_ctrl.flags_in) begin
          flags_q <= flags_d;
        end
        case (i_ctrl.dst)
          SEL_A:   a_q <= int_bus;
          SEL_T:   t_q <= int_bus;
          SEL_B:   b_q <= int_bus;
          SEL_C:   c_q <= int_bus;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (step_en && i_ctrl.mar_in) begin
      mar_q <= int_bus;
    end
    if (step_en && i_ctrl.out_in) begin
      out_q <= int_bus;
    end
  end

  assign o_instr     = opcode_e'(ir_q);
  assign o_flags     = flags_q;
  assign o_mar       = mar_q;
  assign o_out_data  = out_q;
  assign o_out_valid = out_valid_q;

  // The microcode must never drive the internal bus from two places at once
  a_single_source: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_ctrl.alu_out |-> (i_ctrl.src == SEL_NONE && !i_ctrl.pc_out));

endmodule

//--- design/micro_sequencer.sv
`timescale 1ns/1ns
// Decode stage of the CPU. Walks each instruction through its microsteps and
// drives the control word, the bus read request and the halted status

module micro_sequencer (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  cpu_pkg::opcode_e    i_instr,
  input  cpu_pkg::flags_t     i_flags,
  input  logic                i_rd_done,
  output cpu_pkg::ctrl_word_t o_ctrl,
  output logic                o_rd_req,
  output logic                o_halted
);
  import cpu_pkg::*;

  step_e      step_q;
  logic       halted_q;
  logic       rd_pend_q;
  logic       step_en;
  logic [7:0] op;
  logic [3:0] mov_idx;
  logic [1:0] mov_rem;
  logic [1:0] mov_src_idx;
  logic [1:0] mov_dst_idx;
  logic [1:0] ldi_idx;
  reg_sel_e   alu_sel;
  logic       jump_taken;

  function automatic reg_sel_e reg_from_idx(input logic [1:0] idx);
    return reg_sel_e'({1'b0, idx} + 3'd1);
  endfunction

  assign op = i_instr;

  // MOV opcodes run source-major over A, T, B, C, each source skipping itself
  always_comb begin
    mov_idx     = 4'(op - 8'(OP_MOV_AT));
    mov_src_idx = 2'(mov_idx / 4'd3);
    mov_rem     = 2'(mov_idx % 4'd3);
    mov_dst_idx = (mov_rem >= mov_src_idx) ? mov_rem + 2'd1 : mov_rem;
  end

  // LDI targets A, B and C, which skips T in the register index
  assign ldi_idx = (op[1:0] == 2'd0) ? 2'd0 : op[1:0] + 2'd1;
  assign alu_sel = op[1] ? SEL_C : SEL_B;

  always_comb begin
    case (i_instr)
      OP_JIZ:  jump_taken = i_flags.zero;
      OP_JIC:  jump_taken = i_flags.carry;
      default: jump_taken = 1'b1;
    endcase
  end

  always_comb begin
    o_ctrl = '0;
    case (step_q)
      STEP_FETCH_ADDR: begin
        o_ctrl.pc_out = 1'b1;
        o_ctrl.mar_in = 1'b1;
      end
      STEP_FETCH_DATA: begin
        o_ctrl.mem_rd = 1'b1;
        o_ctrl.src    = SEL_MEM;
        o_ctrl.ir_in  = 1'b1;
        o_ctrl.pc_inc = 1'b1;
      end
      default: begin
        case (i_instr)
          OP_LDI_A, OP_LDI_B, OP_LDI_C: begin
            if (step_q == STEP_EX2) begin
              o_ctrl.pc_out = 1'b1;
              o_ctrl.mar_in = 1'b1;
            end else begin
              o_ctrl.mem_rd  = 1'b1;
              o_ctrl.src     = SEL_MEM;
              o_ctrl.pc_inc  = 1'b1;
              o_ctrl.dst     = reg_from_idx(ldi_idx);
              o_ctrl.advance = 1'b1;
            end
          end
          OP_MOV_AT, OP_MOV_AB, OP_MOV_AC, OP_MOV_TA, OP_MOV_TB, OP_MOV_TC,
          OP_MOV_BA, OP_MOV_BT, OP_MOV_BC, OP_MOV_CA, OP_MOV_CT, OP_MOV_CB: begin
            o_ctrl.src     = reg_from_idx(mov_src_idx);
            o_ctrl.dst     = reg_from_idx(mov_dst_idx);
            o_ctrl.advance = 1'b1;
          end
          OP_OUT_A, OP_OUT_T, OP_OUT_B, OP_OUT_C: begin
            o_ctrl.src     = reg_from_idx(op[1:0]);
            o_ctrl.out_in  = 1'b1;
            o_ctrl.advance = 1'b1;
          end
          OP_JUMP, OP_JIZ, OP_JIC: begin
            if (step_q == STEP_EX2) begin
              o_ctrl.pc_out = 1'b1;
              o_ctrl.mar_in = 1'b1;
              o_ctrl.pc_inc = 1'b1;
            end else begin
              // A jump not taken leaves the PC already past the target byte
              o_ctrl.mem_rd  = 1'b1;
              o_ctrl.src     = SEL_MEM;
              o_ctrl.jump    = jump_taken;
              o_ctrl.advance = 1'b1;
            end
          end
          OP_ADDB, OP_SUBB, OP_ADDC, OP_SUBC: begin
            o_ctrl.dst = SEL_T;
            if (step_q == STEP_EX2) begin
              o_ctrl.src = alu_sel;
            end else begin
              o_ctrl.alu_out  = 1'b1;
              o_ctrl.sub      = op[0];
              o_ctrl.flags_in = 1'b1;
              o_ctrl.advance  = 1'b1;
            end
          end
          OP_HALT: o_ctrl.halt = 1'b1;
          default: o_ctrl.advance = 1'b1;
        endcase
      end
    endcase
  end

  // A read step holds until the bus master reports done
  assign step_en  = !o_ctrl.mem_rd || i_rd_done;
  assign o_rd_req = o_ctrl.mem_rd && !rd_pend_q;
  assign o_halted = halted_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      step_q    <= STEP_FETCH_ADDR;
      halted_q  <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (o_rd_req) begin
        rd_pend_q <= 1'b1;
      end else if (i_rd_done) begin
        rd_pend_q <= 1'b0;
      end
      if (o_ctrl.halt) begin
        halted_q <= 1'b1;
      end
      if (step_en && !o_ctrl.halt) begin
        step_q <= o_ctrl.advance ? STEP_FETCH_ADDR : step_e'(step_q + 2'd1);
      end
    end
  end

  // No instruction may step on past its last microstep
  a_step_range: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (step_en && !o_ctrl.halt && !o_ctrl.advance) |-> int'(step_q) < MAX_STEP);

  a_halt_no_read: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_ctrl.halt && o_ctrl.mem_rd));

endmodule

//--- verification/tb_model.svh
// Random program generator and reference instruction model of the CPU
// Included in the testbench module, which declares the memory and the expected lists
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] ins_op  [0:255];
logic [7:0] ins_arg [0:255];
int         ins_cnt  = 0;
int         byte_cnt = 0;

// Galois LFSR with taps 16, 14, 13 and 11, one output bit per step
function automatic logic take_bit();
  logic lsb;
  lsb    = lfsr_q[0];
  lfsr_q = lfsr_q >> 1;
  if (lsb) begin
    lfsr_q = lfsr_q ^ 16'hb400;
  end
  return lsb;
endfunction

function automatic logic [7:0] rand_bits(input int n);
  logic [7:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[6:0], take_bit()};
  end
  return v;
endfunction

// LDI and the three jumps carry one operand byte
function automatic bit has_operand(input logic [7:0] op);
  return op >= 8'h24 && op <= 8'h29;
endfunction

// Upper two bits are the source, lower two the destination, indices over A, T, B, C
function automatic logic [3:0] mov_regs(input logic [3:0] idx);
  case (idx)
    4'd0:    return 4'h1;
    4'd1:    return 4'h2;
    4'd2:    return 4'h3;
    4'd3:    return 4'h4;
    4'd4:    return 4'h6;
    4'd5:    return 4'h7;
    4'd6:    return 4'h8;
    4'd7:    return 4'h9;
    4'd8:    return 4'hb;
    4'd9:    return 4'hc;
    4'd10:   return 4'hd;
    default: return 4'he;
  endcase
endfunction

// For jumps the argument is a forward distance in instructions until layout
task automatic push_ins(input logic [7:0] op, input logic [7:0] arg);
  ins_op[8'(ins_cnt)]  = op;
  ins_arg[8'(ins_cnt)] = arg;
  ins_cnt++;
  byte_cnt += has_operand(op) ? 2 : 1;
endtask

task automatic build_program();
  logic [2:0] pick;
  logic [7:0] val;
  logic [7:0] op;
  logic [7:0] at;
  logic [7:0] addr [0:255];
  int         tgt;
  for (int i = 0; i < 256; i++) begin
    mem[8'(i)] = 8'(i * 37) ^ 8'ha5;
    ack_delays[8'(i)] = 2'(rand_bits(2));
  end
  while (byte_cnt < 180) begin
    pick = 3'(rand_bits(3));
    case (pick)
      3'd0: push_ins(8'h24 + rand_bits(2) % 8'd3, rand_bits(8));
      3'd1: push_ins(8'h20 + rand_bits(2), 8'd0);
      3'd2: push_ins(8'h08 + rand_bits(4) % 8'd12, 8'd0);
      3'd3: begin
        push_ins(8'h34 + rand_bits(2), 8'd0);
        push_ins(8'h21, 8'd0);
      end
      3'd4: begin
        push_ins(8'h34 + rand_bits(2), 8'd0);
        push_ins(8'h28 + rand_bits(1), 8'd1 + rand_bits(2));
      end
      3'd5: begin
        // Equal operands give a zero result with carry set
        val = rand_bits(8);
        push_ins(8'h24, val);
        push_ins(8'h25, val);
        push_ins(8'h35, 8'd0);
        push_ins(8'h28 + rand_bits(1), 8'd1 + rand_bits(2));
      end
      3'd6: push_ins(8'h27, 8'd1 + rand_bits(2));
      default: push_ins(rand_bits(3), 8'd0);
    endcase
  end
  push_ins(8'h20, 8'd0);
  push_ins(8'hff, 8'd0);
  at = 8'd0;
  for (int i = 0; i < ins_cnt; i++) begin
    addr[8'(i)] = at;
    at = at + (has_operand(ins_op[8'(i)]) ? 8'd2 : 8'd1);
  end
  // Jump targets land on a later instruction, at the latest the OUT before HALT
  for (int i = 0; i < ins_cnt; i++) begin
    op = ins_op[8'(i)];
    mem[addr[8'(i)]] = op;
    if (op >= 8'h27 && op <= 8'h29) begin
      tgt = i + int'(ins_arg[8'(i)]);
      if (tgt > ins_cnt - 2) begin
        tgt = ins_cnt - 2;
      end
      mem[addr[8'(i)] + 8'd1] = addr[8'(tgt)];
    end else if (has_operand(op)) begin
      mem[addr[8'(i)] + 8'd1] = ins_arg[8'(i)];
    end
  end
endtask

// Walks the program one instruction at a time and records bus reads and OUT values
task automatic run_model();
  logic [7:0] regs [0:3];
  logic [7:0] pc;
  logic [7:0] op;
  logic [7:0] opnd;
  logic [8:0] sum;
  logic [1:0] src;
  logic [1:0] dst;
  logic       zero;
  logic       carry;
  bit         done;
  int         guard;
  for (int i = 0; i < 4; i++) begin
    regs[2'(i)] = 8'd0;
  end
  pc    = 8'd0;
  opnd  = 8'd0;
  zero  = 1'b0;
  carry = 1'b0;
  done  = 1'b0;
  guard = 0;
  while (!done && guard < 1000) begin
    guard++;
    exp_adr.push_back(pc);
    op = mem[pc];
    pc++;
    if (has_operand(op)) begin
      exp_adr.push_back(pc);
      opnd = mem[pc];
      pc++;
    end
    case (op) inside
      [8'h08:8'h13]: begin
        {src, dst} = mov_regs(4'(op - 8'h08));
        regs[dst] = regs[src];
      end
      [8'h20:8'h23]: exp_out.push_back(regs[op[1:0]]);
      8'h24: regs[0] = opnd;
      8'h25: regs[2] = opnd;
      8'h26: regs[3] = opnd;
      8'h27: pc = opnd;
      8'h28: begin
        if (zero) begin
          pc = opnd;
        end
      end
      8'h29: begin
        if (carry) begin
          pc = opnd;
        end
      end
      [8'h34:8'h37]: begin
        regs[1] = op[1] ? regs[3] : regs[2];
        if (op[0]) begin
          sum = {1'b0, regs[0]} + {1'b0, ~regs[1]} + 9'd1;
        end else begin
          sum = {1'b0, regs[0]} + {1'b0, regs[1]};
        end
        regs[1] = sum[7:0];
        zero    = (sum[7:0] == 8'd0);
        carry   = sum[8];
      end
      8'hff: done = 1'b1;
      default: ;
    endcase
  end
endtask

`endif

//--- verification/tb_cpu.sv
`timescale 1ns/1ns
// Testbench for the CPU. Runs a random program from a Wishbone memory with random
// ack delays and compares bus addresses and OUT values with a reference model

module tb_cpu;
  import cpu_pkg::*;

  logic                  clk    = 1'b0;
  logic                  arst_n = 1'b0;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic [ADDR_WIDTH-1:0] wb_adr;
  logic [DATA_WIDTH-1:0] wb_dat = '0;
  logic                  wb_ack = 1'b0;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_valid;
  logic                  halted;

  logic [15:0] lfsr_q = 16'd14;
  logic [7:0]  mem        [0:255];
  logic [1:0]  ack_delays [0:255];
  logic [7:0]  exp_adr    [$];
  logic [7:0]  exp_out    [$];
  logic        serving  = 1'b0;
  logic [1:0]  ack_wait = 2'd0;
  logic [7:0]  held_adr = 8'd0;
  int          rd_idx   = 0;
  int          out_idx  = 0;
  int          cycles;

  `include "tb_model.svh"

  cpu_top dut0 (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .o_wb_cyc    (wb_cyc),
    .o_wb_stb    (wb_stb),
    .o_wb_adr    (wb_adr),
    .i_wb_dat    (wb_dat),
    .i_wb_ack    (wb_ack),
    .o_out_data  (out_data),
    .o_out_valid (out_valid),
    .o_halted    (halted)
  );

  always #50 clk = ~clk;

  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "Run stopped after the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    stop_failed();
  endtask

  // Wishbone slave memory, each strobe is acked after 0 to 3 extra cycles
  always @(posedge clk) begin
    if (!arst_n || wb_ack) begin
      wb_ack  <= 1'b0;
      serving = 1'b0;
    end else if (wb_stb) begin
      if (!serving) begin
        serving  = 1'b1;
        held_adr = wb_adr;
        ack_wait = ack_delays[8'(rd_idx)];
        assert (rd_idx < exp_adr.size())
          else abort_run("bus read after the last address the model expects");
        assert (wb_adr == exp_adr[rd_idx])
          else report_mismatch($sformatf("read %0d at address %02h, expected %02h",
                                         rd_idx, wb_adr, exp_adr[rd_idx]));
        rd_idx++;
      end
      assert (wb_cyc)
        else report_mismatch($sformatf("strobe at address %02h without cyc", wb_adr));
      assert (wb_adr == held_adr)
        else report_mismatch($sformatf("address moved to %02h before ack", wb_adr));
      if (ack_wait == 2'd0) begin
        wb_ack <= 1'b1;
        wb_dat <= mem[wb_adr];
      end else begin
        ack_wait = ack_wait - 2'd1;
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && out_valid) begin
      assert (out_idx < exp_out.size())
        else abort_run("OUT value after the last one the model expects");
      assert (out_data == exp_out[out_idx])
        else report_mismatch($sformatf("OUT %0d gave %02h, expected %02h",
                                       out_idx, out_data, exp_out[out_idx]));
      out_idx++;
    end else if (arst_n && out_idx > 0) begin
      // The port keeps the last OUT value until the next OUT
      assert (out_data == exp_out[out_idx - 1])
        else report_mismatch($sformatf("OUT data changed to %02h between OUTs", out_data));
    end
  end

  initial begin
    build_program();
    run_model();
    $display("Program of %0d instructions, %0d OUT values expected", ins_cnt, exp_out.size());
    // Registers take their reset values at the first edge
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        assert (!wb_cyc && !wb_stb && !out_valid && !halted)
          else report_mismatch("bus or status output active during reset");
      end
    end
    arst_n <= 1'b1;
    cycles = 0;
    while (!wb_stb && cycles < 20) begin
      @(posedge clk);
      assert (!out_valid && !halted && wb_cyc == wb_stb)
        else report_mismatch("output active before the first fetch");
      cycles++;
    end
    assert (wb_stb) else abort_run("no bus cycle started after reset");
    cycles = 0;
    while (!halted && cycles < 5000) begin
      @(posedge clk);
      cycles++;
    end
    assert (halted) else abort_run("timeout while waiting for the CPU to halt");
    for (int i = 0; i < 50; i++) begin
      @(posedge clk);
      assert (halted && !wb_stb && !wb_cyc)
        else report_mismatch("bus cycle or halted low after HALT");
    end
    assert (out_idx == exp_out.size())
      else report_mismatch($sformatf("%0d of %0d OUT values seen", out_idx, exp_out.size()));
    assert (rd_idx == exp_adr.size())
      else report_mismatch($sformatf("%0d of %0d bus reads seen", rd_idx, exp_adr.size()));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog.f
design/cpu_pkg.sv
design/bus_master.sv
design/datapath.sv
design/micro_sequencer.sv
design/cpu_top.sv
verification/tb_cpu.sv
+incdir+verification
